// ==== source/mips_defines.svh ====
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// core-wide sizes and fixed addresses

// data and address width
`define MIPS_XLEN 32

// architectural register count
`define MIPS_NREGS 32

// first instruction fetched after reset
`define MIPS_RESET_VECTOR 32'hBFC00000

// jal writes the return address here
`define MIPS_LINK_REG 5'd31

// v0 holds the program result
`define MIPS_V0_REG 5'd2

// width of an immediate field
`define MIPS_IMM_W 16

`endif

// ==== source/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_decode,
        st_exec1,
        st_exec2,
        st_halted
    } state_t;

    // supported primary opcodes
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_t;

    // supported function codes under op_special
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_jr   = 6'h08,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_lui
    } alu_op_t;

    typedef enum logic [2:0] {
        pc_plus4,
        pc_beq,
        pc_bne,
        pc_jump,
        pc_reg
    } pc_sel_t;

    // one instruction word, three field layouts
    typedef union packed {
        struct packed {
            opcode_t    opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            funct_t     funct;
        } r;
        struct packed {
            opcode_t     opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
        struct packed {
            opcode_t     opcode;
            logic [25:0] target;
        } j;
    } instr_t;

endpackage

`default_nettype wire

// ==== source/mips_ctrl_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface mips_ctrl_if;
    import mips_pkg::*;

    // strobes and selects from the control unit
    alu_op_t alu_op;
    logic    alu_src_imm;
    logic    sign_ext;
    logic    reg_dst_rd;
    logic    mem_to_reg;
    logic    link;
    logic    reg_write;
    logic    ir_write;
    logic    pc_write;
    pc_sel_t pc_sel;
    logic    addr_pc;

    // instruction register, back to the decoder
    instr_t  ir;

    modport control (
        output alu_op, alu_src_imm, sign_ext, reg_dst_rd, mem_to_reg, link,
        output reg_write, ir_write, pc_write, pc_sel, addr_pc,
        input  ir
    );

    modport datapath (
        input  alu_op, alu_src_imm, sign_ext, reg_dst_rd, mem_to_reg, link,
        input  reg_write, ir_write, pc_write, pc_sel, addr_pc,
        output ir
    );

endinterface

`default_nettype wire

// ==== source/mips_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_defines.svh"

module mips_alu (
    input  logic [`MIPS_XLEN-1:0] a,
    input  logic [`MIPS_XLEN-1:0] b,
    input  mips_pkg::alu_op_t     op,
    input  logic [4:0]            shamt,
    output logic [`MIPS_XLEN-1:0] result,
    output logic                  zero
);
    import mips_pkg::*;

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_slt:  result = {{(`MIPS_XLEN-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(`MIPS_XLEN-1){1'b0}}, lt_unsigned};
            // shifts act on the rt operand
            alu_sll:  result = b << shamt;
            alu_srl:  result = b >> shamt;
            alu_lui:  result = {b[`MIPS_IMM_W-1:0], {(`MIPS_XLEN-`MIPS_IMM_W){1'b0}}};
            default:  result = '0;
        endcase
    end

    // beq and bne look at this after a subtract
    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== source/mips_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_defines.svh"

module mips_regfile #(
    parameter int depth = `MIPS_NREGS,
    parameter int width = `MIPS_XLEN
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             write_enable,
    input  logic [4:0]       read_index1,
    input  logic [4:0]       read_index2,
    input  logic [4:0]       write_index,
    input  logic [width-1:0] write_data,
    output logic [width-1:0] read_data1,
    output logic [width-1:0] read_data2,
    output logic [width-1:0] v0
);

    logic [width-1:0] regs [depth];

    // register zero is never written so it reads as zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < depth; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && (write_index != 5'd0)) begin
            regs[write_index] <= write_data;
        end
    end

    assign read_data1 = regs[read_index1];
    assign read_data2 = regs[read_index2];
    assign v0         = regs[`MIPS_V0_REG];

endmodule

`default_nettype wire

// ==== source/mips_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_control (
    input  logic clk,
    input  logic arst_n,
    input  logic waitrequest,
    output logic active,
    output logic read,
    output logic write,
    mips_ctrl_if.control ctrl,
    input  logic pc_zero
);
    import mips_pkg::*;

    state_t  state;
    state_t  state_next;

    // decoded from ir, held for the whole instruction
    alu_op_t dec_alu_op;
    logic    dec_imm;
    logic    dec_sign_ext;
    logic    dec_rd;
    logic    dec_link;
    logic    dec_writes_reg;
    logic    dec_load;
    logic    dec_store;
    pc_sel_t dec_pc_sel;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else if (!waitrequest) begin
            state <= state_next;
        end
    end

    // pc_zero already reflects the pc about to be loaded
    always_comb begin
        case (state)
            st_idle:   state_next = pc_zero ? st_halted : st_fetch;
            st_fetch:  state_next = st_decode;
            st_decode: state_next = st_exec1;
            st_exec1:  state_next = st_exec2;
            st_exec2:  state_next = pc_zero ? st_halted : st_fetch;
            default:   state_next = st_halted;
        endcase
    end

    always_comb begin
        dec_alu_op     = alu_add;
        dec_imm        = 1'b0;
        dec_sign_ext   = 1'b1;
        dec_rd         = 1'b0;
        dec_link       = 1'b0;
        dec_writes_reg = 1'b0;
        dec_load       = 1'b0;
        dec_store      = 1'b0;
        dec_pc_sel     = pc_plus4;
        case (ctrl.ir.r.opcode)
            op_special: begin
                dec_rd         = 1'b1;
                dec_writes_reg = 1'b1;
                case (ctrl.ir.r.funct)
                    fn_addu: dec_alu_op = alu_add;
                    fn_subu: dec_alu_op = alu_sub;
                    fn_and:  dec_alu_op = alu_and;
                    fn_or:   dec_alu_op = alu_or;
                    fn_xor:  dec_alu_op = alu_xor;
                    fn_slt:  dec_alu_op = alu_slt;
                    fn_sltu: dec_alu_op = alu_sltu;
                    fn_sll:  dec_alu_op = alu_sll;
                    fn_srl:  dec_alu_op = alu_srl;
                    fn_jr: begin
                        dec_writes_reg = 1'b0;
                        dec_pc_sel     = pc_reg;
                    end
                    // unknown function acts as a nop
                    default: dec_writes_reg = 1'b0;
                endcase
            end
            op_j: dec_pc_sel = pc_jump;
            op_jal: begin
                dec_pc_sel     = pc_jump;
                dec_link       = 1'b1;
                dec_writes_reg = 1'b1;
            end
            op_beq, op_bne: begin
                dec_alu_op = alu_sub;
                dec_pc_sel = (ctrl.ir.r.opcode == op_beq) ? pc_beq : pc_bne;
            end
            op_addiu, op_slti, op_lui: begin
                dec_imm        = 1'b1;
                dec_writes_reg = 1'b1;
                dec_alu_op     = (ctrl.ir.r.opcode == op_addiu) ? alu_add :
                                 (ctrl.ir.r.opcode == op_slti)  ? alu_slt : alu_lui;
            end
            op_andi, op_ori, op_xori: begin
                dec_imm        = 1'b1;
                dec_sign_ext   = 1'b0;
                dec_writes_reg = 1'b1;
                dec_alu_op     = (ctrl.ir.r.opcode == op_andi) ? alu_and :
                                 (ctrl.ir.r.opcode == op_ori)  ? alu_or : alu_xor;
            end
            op_lw: begin
                dec_imm        = 1'b1;
                dec_load       = 1'b1;
                dec_writes_reg = 1'b1;
            end
            op_sw: begin
                dec_imm   = 1'b1;
                dec_store = 1'b1;
            end
            default: dec_pc_sel = pc_plus4;
        endcase
    end

    assign active = (state != st_idle) && (state != st_halted);

    // bus strobes only in fetch and memory exec1
    assign read  = (state == st_fetch) || ((state == st_exec1) && dec_load);
    assign write = (state == st_exec1) && dec_store;

    assign ctrl.addr_pc     = (state != st_exec1);
    assign ctrl.ir_write    = (state == st_fetch);
    assign ctrl.pc_write    = (state == st_exec2);
    assign ctrl.reg_write   = (state == st_exec2) && dec_writes_reg;
    assign ctrl.alu_op      = dec_alu_op;
    assign ctrl.alu_src_imm = dec_imm;
    assign ctrl.sign_ext    = dec_sign_ext;
    assign ctrl.reg_dst_rd  = dec_rd;
    assign ctrl.mem_to_reg  = dec_load;
    assign ctrl.link        = dec_link;
    assign ctrl.pc_sel      = dec_pc_sel;

endmodule

`default_nettype wire

// ==== source/mips_datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_defines.svh"

module mips_datapath (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  waitrequest,
    input  logic [`MIPS_XLEN-1:0] readdata,
    output logic [`MIPS_XLEN-1:0] address,
    output logic [`MIPS_XLEN-1:0] writedata,
    output logic [`MIPS_XLEN-1:0] register_v0,
    output logic                  pc_zero,
    mips_ctrl_if.datapath         ctrl
);
    import mips_pkg::*;

    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] pc_plus4;
    logic [`MIPS_XLEN-1:0] pc_next;
    logic [`MIPS_XLEN-1:0] pc_d;
    logic [`MIPS_XLEN-1:0] branch_target;
    logic [`MIPS_XLEN-1:0] jump_target;
    instr_t                ir;
    logic [`MIPS_XLEN-1:0] mdr;

    logic [`MIPS_XLEN-1:0] rs_data;
    logic [`MIPS_XLEN-1:0] rt_data;
    logic [`MIPS_XLEN-1:0] imm_ext;
    logic [`MIPS_XLEN-1:0] alu_b;
    logic [`MIPS_XLEN-1:0] alu_result;
    logic                  alu_zero;
    logic [4:0]            wr_index;
    logic [`MIPS_XLEN-1:0] wr_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `MIPS_RESET_VECTOR;
        end else if (ctrl.pc_write && !waitrequest) begin
            pc <= pc_next;
        end
    end

    // mdr captures load data on the edge that ends exec1
    always_ff @(posedge clk) begin
        if (ctrl.ir_write && !waitrequest) begin
            ir <= readdata;
        end
        if (!waitrequest) begin
            mdr <= readdata;
        end
    end

    assign ctrl.ir = ir;

    assign imm_ext = ctrl.sign_ext ?
        {{(`MIPS_XLEN-`MIPS_IMM_W){ir.i.imm[`MIPS_IMM_W-1]}}, ir.i.imm} :
        {{(`MIPS_XLEN-`MIPS_IMM_W){1'b0}}, ir.i.imm};

    assign alu_b = ctrl.alu_src_imm ? imm_ext : rt_data;

    mips_alu alu_i (
        .a      (rs_data),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .shamt  (ir.r.shamt),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // write-back select
    assign wr_index = ctrl.link       ? `MIPS_LINK_REG :
                      ctrl.reg_dst_rd ? ir.r.rd : ir.r.rt;
    assign wr_data  = ctrl.link       ? pc_plus4 :
                      ctrl.mem_to_reg ? mdr : alu_result;

    mips_regfile #(
        .depth (`MIPS_NREGS),
        .width (`MIPS_XLEN)
    ) regfile_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .write_enable (ctrl.reg_write && !waitrequest),
        .read_index1  (ir.r.rs),
        .read_index2  (ir.r.rt),
        .write_index  (wr_index),
        .write_data   (wr_data),
        .read_data1   (rs_data),
        .read_data2   (rt_data),
        .v0           (register_v0)
    );

    // next pc, no delay slot
    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {imm_ext[`MIPS_XLEN-3:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], ir.j.target, 2'b00};

    always_comb begin
        case (ctrl.pc_sel)
            pc_beq:  pc_next = alu_zero ? branch_target : pc_plus4;
            pc_bne:  pc_next = alu_zero ? pc_plus4 : branch_target;
            pc_jump: pc_next = jump_target;
            pc_reg:  pc_next = rs_data;
            default: pc_next = pc_plus4;
        endcase
    end

    // value the pc holds when the next fetch would start
    assign pc_d    = ctrl.pc_write ? pc_next : pc;
    assign pc_zero = (pc_d == '0);

    assign address   = ctrl.addr_pc ? pc : alu_result;
    assign writedata = rt_data;

endmodule

`default_nettype wire

// ==== source/mips_cpu_bus.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_defines.svh"

module mips_cpu_bus (
    input  logic                  clk,
    input  logic                  arst_n,
    output logic                  active,
    output logic [`MIPS_XLEN-1:0] register_v0,

    // avalon master, shared by fetch and data
    output logic [`MIPS_XLEN-1:0] address,
    output logic                  read,
    output logic                  write,
    output logic [`MIPS_XLEN-1:0] writedata,
    output logic [3:0]            byteenable,
    input  logic [`MIPS_XLEN-1:0] readdata,
    input  logic                  waitrequest
);

    logic pc_zero;

    mips_ctrl_if ctrl_if ();

    mips_control control_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .waitrequest (waitrequest),
        .active      (active),
        .read        (read),
        .write       (write),
        .ctrl        (ctrl_if.control),
        .pc_zero     (pc_zero)
    );

    mips_datapath datapath_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .address     (address),
        .writedata   (writedata),
        .register_v0 (register_v0),
        .pc_zero     (pc_zero),
        .ctrl        (ctrl_if.datapath)
    );

    // word accesses only
    assign byteenable = 4'b1111;

endmodule

`default_nettype wire

// ==== dv/mips_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_defines.svh"

module mips_checker (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  active,
    input  logic [`MIPS_XLEN-1:0] register_v0,
    input  logic [`MIPS_XLEN-1:0] address,
    input  logic                  read,
    input  logic                  write,
    input  logic [`MIPS_XLEN-1:0] writedata,
    input  logic [3:0]            byteenable,
    input  logic                  waitrequest,
    input  int                    test_id,
    input  logic [`MIPS_XLEN-1:0] exp_v0,
    input  logic [`MIPS_XLEN-1:0] exp_st_addr,
    input  logic [`MIPS_XLEN-1:0] exp_st_data,
    input  logic                  test_end,
    input  logic                  report,
    output int                    tests_run,
    output int                    tests_failed
);

    int                    errors;
    logic                  seen_active;
    logic                  halted;
    logic                  seen_read;
    logic                  store_seen;
    logic [`MIPS_XLEN-1:0] st_addr;
    logic [`MIPS_XLEN-1:0] st_data;

    // a transfer stalled last cycle must be held unchanged
    logic                  held;
    logic                  held_read;
    logic                  held_write;
    logic [`MIPS_XLEN-1:0] held_addr;
    logic [`MIPS_XLEN-1:0] held_wdata;

    initial begin
        tests_run    = 0;
        tests_failed = 0;
        errors       = 0;
        held         = 1'b0;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, want, got);
            errors++;
        end
    endtask

    task automatic flag_error(input string what);
        $display("ERROR t=%0t %s", $time, what);
        errors++;
    endtask

    task automatic close_test();
        if (!halted) begin
            flag_error("core did not halt before the end of the test");
        end
        // zero store address means no store expected
        if (exp_st_addr == '0) begin
            if (store_seen) begin
                flag_error("a store happened in a test that expects none");
            end
        end else if (!store_seen) begin
            flag_error("the expected store never happened");
        end else begin
            check_value("address", st_addr, exp_st_addr);
            check_value("writedata", st_data, exp_st_data);
        end
        tests_run++;
        if (errors == 0) begin
            $display("test %0d passed", test_id);
        end else begin
            $display("test %0d failed with %0d errors", test_id, errors);
            tests_failed++;
        end
        errors = 0;
    endtask

    // outputs sampled at the rising edge before the DUT updates
    always @(posedge clk) begin
        if (!arst_n) begin
            if (active === 1'b1 || read === 1'b1 || write === 1'b1) begin
                flag_error("active or a bus strobe is high during reset");
            end
            seen_active = 1'b0;
            halted      = 1'b0;
            seen_read   = 1'b0;
            store_seen  = 1'b0;
            held        = 1'b0;
        end else begin
            if (read && write) begin
                flag_error("read and write are high together");
            end
            // word accesses only
            if (read || write) begin
                check_value("byteenable", byteenable, 4'b1111);
            end
            if (held) begin
                check_value("read", read, held_read);
                check_value("write", write, held_write);
                check_value("address", address, held_addr);
                if (held_write) begin
                    check_value("writedata", writedata, held_wdata);
                end
            end
            held       = (read || write) && waitrequest;
            held_read  = read;
            held_write = write;
            held_addr  = address;
            held_wdata = writedata;

            if (read && !seen_read) begin
                seen_read = 1'b1;
                if (!active) begin
                    flag_error("first read issued while active is low");
                end
                check_value("address", address, `MIPS_RESET_VECTOR);
            end
            if (write && !waitrequest) begin
                store_seen = 1'b1;
                st_addr    = address;
                st_data    = writedata;
            end

            if (halted) begin
                if (active) begin
                    flag_error("active rose again after the halt");
                end
                if (read || write) begin
                    flag_error("bus activity after the halt");
                end
            end else if (seen_active && !active) begin
                halted = 1'b1;
                check_value("register_v0", register_v0, exp_v0);
            end
            if (active) begin
                seen_active = 1'b1;
            end

            if (test_end) begin
                close_test();
            end
        end
        if (report) begin
            $display("tests run %0d, passed %0d, failed %0d",
                     tests_run, tests_run - tests_failed, tests_failed);
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_mips_cpu_bus.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_defines.svh"

module tb_mips_cpu_bus;

    localparam int          pat_depth    = 512;
    localparam int          prog_depth   = 64;
    localparam int          data_depth   = 256;
    localparam int          reset_cycles = 10;
    localparam int          tail_cycles  = 6;
    localparam logic [31:0] data_base    = 32'h0000_1000;
    localparam logic [31:0] end_mark     = 32'hFFFF_FFFF;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  active;
    logic [`MIPS_XLEN-1:0] register_v0;
    logic [`MIPS_XLEN-1:0] address;
    logic                  read;
    logic                  write;
    logic [`MIPS_XLEN-1:0] writedata;
    logic [3:0]            byteenable;
    logic [`MIPS_XLEN-1:0] readdata;
    logic                  waitrequest;

    logic [31:0] patterns [pat_depth];
    logic [31:0] prog_mem [prog_depth];
    logic [31:0] data_mem [data_depth];
    logic [15:0] lfsr;

    // expected values for the test in progress
    int          test_id;
    logic [31:0] exp_v0;
    logic [31:0] exp_st_addr;
    logic [31:0] exp_st_data;
    logic        test_end;
    logic        report;
    int          tests_run;
    int          tests_failed;
    int          cycle_limit;
    logic        limit_ready;

    mips_cpu_bus dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata),
        .waitrequest (waitrequest)
    );

    mips_checker checker_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .active       (active),
        .register_v0  (register_v0),
        .address      (address),
        .read         (read),
        .write        (write),
        .writedata    (writedata),
        .byteenable   (byteenable),
        .waitrequest  (waitrequest),
        .test_id      (test_id),
        .exp_v0       (exp_v0),
        .exp_st_addr  (exp_st_addr),
        .exp_st_data  (exp_st_data),
        .test_end     (test_end),
        .report       (report),
        .tests_run    (tests_run),
        .tests_failed (tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // fibonacci taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'hA5A5_0F0F;
    endfunction

    function automatic logic [31:0] mem_read(input logic [31:0] addr);
        logic [31:0] prog_off;
        logic [31:0] data_off;
        prog_off = addr - `MIPS_RESET_VECTOR;
        data_off = addr - data_base;
        if (prog_off < 4 * prog_depth) begin
            return prog_mem[prog_off[31:2]];
        end else if (data_off < 4 * data_depth) begin
            return data_mem[data_off[31:2]];
        end
        return fill_word(addr);
    endfunction

    // avalon slave that stalls about one cycle in four
    always @(negedge clk) begin : bus_model
        logic        bit_a;
        logic        bit_b;
        logic        stall;
        logic [31:0] data_off;
        bit_a = lfsr[15];
        lfsr  = lfsr_step(lfsr);
        bit_b = lfsr[15];
        lfsr  = lfsr_step(lfsr);
        stall = bit_a & bit_b;
        waitrequest = stall;
        readdata    = mem_read(address);
        data_off    = address - data_base;
        if (write && !stall && data_off < 4 * data_depth) begin
            data_mem[data_off[31:2]] = writedata;
        end
    end

    task automatic load_memory(input int first, input int n_words);
        for (int i = 0; i < prog_depth; i++) begin
            if (i < n_words) begin
                prog_mem[i] = patterns[first + i];
            end else begin
                prog_mem[i] = fill_word(`MIPS_RESET_VECTOR + 4 * i);
            end
        end
        for (int i = 0; i < data_depth; i++) begin
            data_mem[i] = fill_word(data_base + 4 * i);
        end
    endtask

    task automatic run_test(input int rec);
        @(negedge clk);
        arst_n      = 1'b0;
        test_id     = patterns[rec];
        exp_v0      = patterns[rec + 1];
        exp_st_addr = patterns[rec + 2];
        exp_st_data = patterns[rec + 3];
        load_memory(rec + 6, patterns[rec + 5]);
        repeat (reset_cycles) @(negedge clk);
        arst_n = 1'b1;
        // core starts, runs, then drops active at the halt
        while (!active) @(negedge clk);
        while (active) @(negedge clk);
        repeat (tail_cycles) @(negedge clk);
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    initial begin
        int rec;
        int budget_sum;
        int records;
        arst_n      = 1'b0;
        waitrequest = 1'b0;
        readdata    = '0;
        test_id     = 0;
        exp_v0      = '0;
        exp_st_addr = '0;
        exp_st_data = '0;
        test_end    = 1'b0;
        report      = 1'b0;
        cycle_limit = 0;
        limit_ready = 1'b0;
        lfsr        = 16'd58;
        for (int i = 0; i < pat_depth; i++) begin
            patterns[i] = end_mark;
        end
        $readmemh("dv/mips_patterns.hex", patterns);

        // 4 states per step and a 4x margin for stalls
        rec        = 0;
        budget_sum = 0;
        records    = 0;
        while (rec < pat_depth && patterns[rec] != end_mark) begin
            budget_sum += patterns[rec + 4];
            records++;
            rec += 6 + patterns[rec + 5];
        end
        cycle_limit = budget_sum * 4 * 4 + records * (reset_cycles + tail_cycles + 2) + 4;
        limit_ready = 1'b1;
        if (records == 0) begin
            $display("no test records found in the pattern file");
        end

        rec = 0;
        while (rec < pat_depth && patterns[rec] != end_mark) begin
            run_test(rec);
            rec += 6 + patterns[rec + 5];
        end

        @(negedge clk);
        report = 1'b1;
        @(negedge clk);
        report = 1'b0;
        if (records > 0 && tests_run == records && tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        int cycles;
        cycles = 0;
        wait (limit_ready);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the tests did not finish within %0d cycles", cycle_limit);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/mips_patterns.hex ====
// header: test id, expected v0, last store address, last store data, step budget, word count
// then the program words, loaded at the reset vector; store address 0 means no store

// alu and logic ops
00000001 12345F8F 00000000 00000000 0000000E 0000000A
3C081234 35085678 2409FFF0 01095021 01485823
01685824 396B00FF 31290F0F 01691025 00000008

// shifts, compares, lui
00000002 ABCD01F1 00000000 00000000 00000011 0000000D
2408FFF8 00084F02 00095100 0109582A 0109202B
29250010 014B1026 00052A00 00451025 00441021
3C08ABCD 00481025 00000008

// store, load back, store again
00000003 CAFEF00D 00001010 CAFEF00E 0000000C 00000008
24081010 3C09CAFE 3529F00D AD09FFF4 8D02FFF4
244A0001 AD0A0000 00000008

// branches, j, jal and the return through jr
00000004 BFC00033 00000000 00000000 00000012 00000012
24020000 24080005 24090005 11090001 24420100 15090001
24420001 11000001 24420002 15000001 24420200 0FF00010
0BF0000E 24420400 00000008 24420800 005F1021 03E00008

// countdown loop with a backward branch, then a store
00000005 0000000A 00001000 0000000A 00000014 00000007
24080004 24020000 00481021 2508FFFF 1500FFFD AC021000
00000008

FFFFFFFF

// ==== compile.f ====
+incdir+source
source/mips_pkg.sv
source/mips_ctrl_if.sv
source/mips_alu.sv
source/mips_regfile.sv
source/mips_control.sv
source/mips_datapath.sv
source/mips_cpu_bus.sv
dv/mips_checker.sv
dv/tb_mips_cpu_bus.sv
